//--- hw/mmio_pkg.sv
package mmio_pkg;

    localparam int ADDR_W = 32;    // Host address width
    localparam int DATA_W = 32;    // Host data width

    // I/O map as seen by a program
    localparam logic [ADDR_W-1:0] UART_CTRL_ADDR = 32'h8000_0000;  // Status word
    localparam logic [ADDR_W-1:0] UART_RX_ADDR = 32'h8000_0004;    // Received byte
    localparam logic [ADDR_W-1:0] UART_TX_ADDR = 32'h8000_0008;    // Byte to send
    localparam logic [ADDR_W-1:0] CYCLE_ADDR = 32'h8000_0010;      // Cycle counter
    localparam logic [ADDR_W-1:0] CYCLE_RST_ADDR = 32'h8000_0018;  // Write clears counter

    localparam int STAT_TX_READY_BIT = 0;  // Transmit FIFO not full
    localparam int STAT_RX_VALID_BIT = 1;  // Receive FIFO not empty

endpackage

//--- hw/uart_pkg.sv
package uart_pkg;

    localparam int BYTE_W = 8;       // One character
    localparam int DATA_BITS = 8;    // Data bits per frame
    localparam int FRAME_BITS = DATA_BITS + 2;   // Start, data, stop

    // Line levels
    localparam logic IDLE_LEVEL = 1'b1;            // Also the stop bit
    localparam logic START_LEVEL = ~IDLE_LEVEL;

endpackage

//--- hw/byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo
    import uart_pkg::*;
#(
    parameter int FIFO_DEPTH = 32
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              push,
    input  logic [BYTE_W-1:0] din,
    input  logic              pop,
    output logic [BYTE_W-1:0] dout,
    output logic              full,
    output logic              empty
);
    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [BYTE_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic do_push;

    assign do_push = push && !full;   // Dropped when full
    assign dout = mem[rd_ptr];        // Head of queue
    assign count_next = count + CNT_W'(do_push) - CNT_W'(pop);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
            full <= 1'b0;
            empty <= 1'b1;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);  // Wraps since depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            count <= count_next;
            full <= (count_next == CNT_W'(FIFO_DEPTH));
            empty <= (count_next == '0);
        end
    end

    // Both consumers are expected to check empty before popping
    pop_when_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("byte_fifo: pop while empty");

endmodule

//--- hw/baud_timer.sv
`timescale 1ns/1ps

module baud_timer #(
    parameter int CLOCK_FREQ = 50_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic clk,
    input  logic reset,
    input  logic start,
    output logic mid_tick,
    output logic bit_tick
);
    localparam int PERIOD = CLOCK_FREQ / BAUD_RATE;   // Cycles per bit
    localparam int CNT_W = $clog2(PERIOD);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(PERIOD - 1);
    localparam logic [CNT_W-1:0] MID = CNT_W'(PERIOD / 2 - 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (reset || start) begin
            count <= '0;                 // Period begins on this edge
        end else if (count == LAST) begin
            count <= '0;
        end else begin
            count <= count + CNT_W'(1);
        end
    end

    assign mid_tick = (count == MID);    // Middle of the bit
    assign bit_tick = (count == LAST);   // Last cycle of the bit

endmodule

//--- hw/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
    import uart_pkg::*;
#(
    parameter int CLOCK_FREQ = 50_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              valid,
    input  logic [BYTE_W-1:0] data,
    output logic              take,
    output logic              serial_out
);
    localparam int CNT_W = $clog2(FRAME_BITS);

    logic sending;
    logic start_frame;
    logic bit_tick;
    logic [FRAME_BITS-1:0] shift_reg;
    logic [CNT_W-1:0] bit_cnt;

    assign start_frame = valid && !sending;
    assign serial_out = shift_reg[0];   // LSB goes out first

    baud_timer #(
        .CLOCK_FREQ(CLOCK_FREQ),
        .BAUD_RATE(BAUD_RATE)
    ) baud_timer (
        .clk(clk),
        .reset(reset),
        .start(start_frame),   // Aligns bit periods to the start bit
        .mid_tick(),
        .bit_tick(bit_tick)    // Advance to next bit
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            sending <= 1'b0;
            take <= 1'b0;
            bit_cnt <= '0;
            shift_reg <= {FRAME_BITS{IDLE_LEVEL}};
        end else begin
            take <= start_frame;   // Pops the head byte just latched
            if (start_frame) begin
                sending <= 1'b1;
                bit_cnt <= '0;
                shift_reg <= {IDLE_LEVEL, data, START_LEVEL};
            end else if (sending && bit_tick) begin
                shift_reg <= {IDLE_LEVEL, shift_reg[FRAME_BITS-1:1]};
                bit_cnt <= bit_cnt + CNT_W'(1);
                if (bit_cnt == CNT_W'(FRAME_BITS - 1)) begin
                    sending <= 1'b0;   // Stop bit fully sent
                end
            end
        end
    end

    // Shifting in idle level must leave the line high after every frame
    idle_line_high: assert property (@(posedge clk) disable iff (reset)
        !sending |-> serial_out == IDLE_LEVEL)
        else $error("uart_tx: line not idle while machine is idle");

endmodule

//--- hw/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
    import uart_pkg::*;
#(
    parameter int CLOCK_FREQ = 50_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              serial_in,
    output logic              byte_valid,
    output logic [BYTE_W-1:0] byte_data
);
    localparam int CNT_W = $clog2(DATA_BITS);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA = 2'd2;
    localparam logic [1:0] S_STOP = 2'd3;

    logic [2:0] rx_sync;
    logic rx_bit;
    logic rx_prev;
    logic start_edge;
    logic mid_tick;
    logic [1:0] state;
    logic [CNT_W-1:0] bit_cnt;
    logic [BYTE_W-1:0] shift_reg;

    // Two flops against metastability and a third for edge detection
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_sync <= {3{IDLE_LEVEL}};
        end else begin
            rx_sync <= {rx_sync[1:0], serial_in};
        end
    end

    assign rx_bit = rx_sync[1];
    assign rx_prev = rx_sync[2];
    assign start_edge = (state == S_IDLE) && (rx_prev == IDLE_LEVEL)
                        && (rx_bit == START_LEVEL);
    assign byte_data = shift_reg;

    baud_timer #(
        .CLOCK_FREQ(CLOCK_FREQ),
        .BAUD_RATE(BAUD_RATE)
    ) baud_timer (
        .clk(clk),
        .reset(reset),
        .start(start_edge),   // Lock to the falling edge
        .mid_tick(mid_tick),  // Sample point
        .bit_tick()
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            bit_cnt <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start_edge) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    if (mid_tick) begin
                        bit_cnt <= '0;
                        // A high line at mid-bit was only a glitch
                        state <= (rx_bit == START_LEVEL) ? S_DATA : S_IDLE;
                    end
                end
                S_DATA: begin
                    if (mid_tick) begin
                        bit_cnt <= bit_cnt + CNT_W'(1);
                        if (bit_cnt == CNT_W'(DATA_BITS - 1)) begin
                            state <= S_STOP;
                        end
                    end
                end
                default: begin
                    if (mid_tick) begin
                        byte_valid <= (rx_bit == IDLE_LEVEL);   // Framing check
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_DATA && mid_tick) begin
            shift_reg <= {rx_bit, shift_reg[BYTE_W-1:1]};   // LSB arrives first
        end
    end

endmodule

//--- hw/mmio_regs.sv
`timescale 1ns/1ps

module mmio_regs
    import mmio_pkg::*;
    import uart_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic [ADDR_W-1:0] bus_addr,
    input  logic [DATA_W-1:0] bus_wdata,
    input  logic              bus_we,
    input  logic              bus_re,
    output logic [DATA_W-1:0] bus_rdata,
    output logic              tx_push,
    output logic [BYTE_W-1:0] tx_data,
    input  logic              tx_full,
    output logic              rx_pop,
    input  logic [BYTE_W-1:0] rx_data,
    input  logic              rx_empty
);
    logic [DATA_W-1:0] cycle_count;
    logic [DATA_W-1:0] status_word;
    logic cycle_clear;

    assign tx_push = bus_we && (bus_addr == UART_TX_ADDR);   // FIFO drops it when full
    assign tx_data = bus_wdata[BYTE_W-1:0];
    assign rx_pop = bus_re && (bus_addr == UART_RX_ADDR) && !rx_empty;
    assign cycle_clear = bus_we && (bus_addr == CYCLE_RST_ADDR);   // Data is ignored

    always_comb begin
        status_word = '0;
        status_word[STAT_TX_READY_BIT] = !tx_full;
        status_word[STAT_RX_VALID_BIT] = !rx_empty;
    end

    always_ff @(posedge clk) begin
        if (reset || cycle_clear) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + DATA_W'(1);
        end
    end

    // Read data appears the cycle after bus_re and holds until the next read
    always_ff @(posedge clk) begin
        if (bus_re) begin
            case (bus_addr)
                UART_CTRL_ADDR: bus_rdata <= status_word;
                UART_RX_ADDR: bus_rdata <= DATA_W'(rx_data);   // Stale head if empty
                CYCLE_ADDR: bus_rdata <= cycle_count;
                default: bus_rdata <= '0;
            endcase
        end
    end

    // The host issues at most one access per cycle
    one_access: assert property (@(posedge clk) disable iff (reset) !(bus_we && bus_re))
        else $error("mmio_regs: read and write in the same cycle");

endmodule

//--- hw/uart_mmio.sv
`timescale 1ns/1ps

module uart_mmio
    import mmio_pkg::*;
    import uart_pkg::*;
#(
    parameter int CLOCK_FREQ = 50_000_000,
    parameter int BAUD_RATE = 115_200,
    parameter int FIFO_DEPTH = 32
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [ADDR_W-1:0] bus_addr,
    input  logic [DATA_W-1:0] bus_wdata,
    input  logic              bus_we,
    input  logic              bus_re,
    output logic [DATA_W-1:0] bus_rdata,
    input  logic              serial_in,
    output logic              serial_out
);
    // Transmit side
    logic tx_push;
    logic [BYTE_W-1:0] tx_data;
    logic tx_full;
    logic tx_empty;
    logic tx_valid;
    logic tx_take;
    logic [BYTE_W-1:0] tx_head;

    // Receive side
    logic rx_byte_valid;
    logic [BYTE_W-1:0] rx_byte;
    logic rx_pop;
    logic rx_empty;
    logic [BYTE_W-1:0] rx_head;

    assign tx_valid = !tx_empty;

    byte_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) tx_fifo (
        .clk(clk),
        .reset(reset),
        .push(tx_push),   // From mmio_regs
        .din(tx_data),    // From mmio_regs
        .pop(tx_take),    // From uart_tx
        .dout(tx_head),   // To uart_tx
        .full(tx_full),   // To mmio_regs
        .empty(tx_empty)
    );

    uart_tx #(
        .CLOCK_FREQ(CLOCK_FREQ),
        .BAUD_RATE(BAUD_RATE)
    ) uart_tx (
        .clk(clk),
        .reset(reset),
        .valid(tx_valid),
        .data(tx_head),
        .take(tx_take),
        .serial_out(serial_out)
    );

    uart_rx #(
        .CLOCK_FREQ(CLOCK_FREQ),
        .BAUD_RATE(BAUD_RATE)
    ) uart_rx (
        .clk(clk),
        .reset(reset),
        .serial_in(serial_in),
        .byte_valid(rx_byte_valid),   // To rx_fifo
        .byte_data(rx_byte)           // To rx_fifo
    );

    byte_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) rx_fifo (
        .clk(clk),
        .reset(reset),
        .push(rx_byte_valid),   // Lost when full
        .din(rx_byte),
        .pop(rx_pop),           // From mmio_regs
        .dout(rx_head),         // To mmio_regs
        .full(),
        .empty(rx_empty)        // To mmio_regs
    );

    mmio_regs mmio_regs (
        .clk(clk),
        .reset(reset),
        .bus_addr(bus_addr),
        .bus_wdata(bus_wdata),
        .bus_we(bus_we),
        .bus_re(bus_re),
        .bus_rdata(bus_rdata),
        .tx_push(tx_push),
        .tx_data(tx_data),
        .tx_full(tx_full),
        .rx_pop(rx_pop),
        .rx_data(rx_head),
        .rx_empty(rx_empty)
    );

endmodule

//--- bench/uart_mmio_tb.sv
`timescale 1ns/1ps

module uart_mmio_tb
    import mmio_pkg::*;
();
    localparam int CLOCK_FREQ = 10_000_000;
    localparam int BAUD_RATE = 1_000_000;
    localparam int FIFO_DEPTH = 4;
    localparam int BIT_CYCLES = CLOCK_FREQ / BAUD_RATE;   // 10 cycles per bit

    logic clk;
    logic reset;
    logic [ADDR_W-1:0] bus_addr;
    logic [DATA_W-1:0] bus_wdata;
    logic bus_we;
    logic bus_re;
    logic [DATA_W-1:0] bus_rdata;
    logic serial_in;
    logic serial_out;

    int checks;
    int errors;
    int test_errors;
    int tests;
    logic [7:0] lfsr_state;
    logic [7:0] accepted[$];   // Bytes the transmit FIFO took during the fill test
    logic fill_done;

    uart_mmio #(
        .CLOCK_FREQ(CLOCK_FREQ),
        .BAUD_RATE(BAUD_RATE),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) uut (
        .clk(clk),
        .reset(reset),
        .bus_addr(bus_addr),
        .bus_wdata(bus_wdata),
        .bus_we(bus_we),
        .bus_re(bus_re),
        .bus_rdata(bus_rdata),
        .serial_in(serial_in),
        .serial_out(serial_out)
    );

    always #50 clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            $display("ERROR %s: got %h, expected %h", name, got, expected);
            errors++;
            test_errors++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("%s", what);
        errors++;
        test_errors++;
    endtask

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(input logic [7:0] state);
        logic feedback;
        feedback = state[7] ^ state[5] ^ state[4] ^ state[3];
        return {state[6:0], feedback};
    endfunction

    task automatic next_filler_byte(output logic [7:0] value);
        value = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);   // One step per bit
            value = {value[6:0], lfsr_state[0]};
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        bus_addr <= addr;
        bus_wdata <= data;
        bus_we <= 1'b1;
        @(posedge clk);   // Write takes effect here
        bus_we <= 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        bus_addr <= addr;
        bus_re <= 1'b1;
        @(posedge clk);   // DUT samples the read
        bus_re <= 1'b0;
        @(negedge clk);
        data = bus_rdata;
    endtask

    task automatic send_frame(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};   // Stop, data LSB first, start
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            serial_in <= frame[i];
            repeat (BIT_CYCLES - 1) @(posedge clk);
        end
    endtask

    task automatic capture_frame(input int limit, output logic got, output logic [7:0] data);
        logic [9:0] bits;
        int waited;
        got = 1'b0;
        data = '0;
        waited = 0;
        while (!got && waited < limit) begin
            @(negedge clk);
            waited++;
            if (serial_out == 1'b0) begin
                got = 1'b1;
            end
        end
        if (got) begin
            repeat (BIT_CYCLES / 2 - 1) @(negedge clk);   // Middle of the start bit
            bits[0] = serial_out;
            for (int i = 1; i < 10; i++) begin
                repeat (BIT_CYCLES) @(negedge clk);
                bits[i] = serial_out;
            end
            compare_value("serial_out start bit", 32'(bits[0]), 32'h0);
            compare_value("serial_out stop bit", 32'(bits[9]), 32'h1);
            data = bits[8:1];
        end
    endtask

    task automatic expect_frame(input logic [7:0] expected);
        logic got;
        logic [7:0] data;
        capture_frame(400, got, data);
        if (!got) begin
            note_failure($sformatf("no frame on serial_out while expecting %h", expected));
        end else begin
            compare_value("serial_out byte", 32'(data), 32'(expected));
        end
    endtask

    task automatic watch_line_high(input int cycles);
        logic level;
        int i;
        level = 1'b1;
        i = 0;
        while (level == 1'b1 && i < cycles) begin
            @(negedge clk);
            level = serial_out;
            i++;
        end
        compare_value("serial_out", 32'(level), 32'h1);
    endtask

    task automatic poll_status(input logic [31:0] addr, input logic [31:0] mask,
                               input logic [31:0] value);
        logic [31:0] data;
        int tries;
        data = ~value;
        tries = 0;
        while ((data & mask) != value && tries < 300) begin
            bus_read(addr, data);
            tries++;
        end
        if ((data & mask) != value) begin
            note_failure($sformatf("polling %h never gave %h under mask %h", addr, value, mask));
        end
    endtask

    task automatic fill_test();
        logic [31:0] status;
        logic [7:0] value;
        logic [7:0] frame_byte;
        logic got;
        logic lost;
        int captured;
        int guard;
        accepted.delete();
        fill_done = 1'b0;
        lost = 1'b0;
        captured = 0;
        fork
            begin
                status = 32'h1;
                guard = 0;
                while (status[STAT_TX_READY_BIT] && guard < 64) begin
                    bus_read(UART_CTRL_ADDR, status);
                    if (status[STAT_TX_READY_BIT]) begin
                        next_filler_byte(value);
                        bus_write(UART_TX_ADDR, 32'(value));
                        accepted.push_back(value);
                    end
                    guard++;
                end
                if (status[STAT_TX_READY_BIT]) begin
                    note_failure("transmit FIFO never reported full");
                end
                next_filler_byte(value);
                bus_write(UART_TX_ADDR, 32'(value));   // Dropped since the FIFO is full
                fill_done = 1'b1;
            end
            begin
                while (!lost && (!fill_done || captured < accepted.size())) begin
                    capture_frame(400, got, frame_byte);
                    if (!got) begin
                        note_failure("frames stopped before all accepted bytes were sent");
                        lost = 1'b1;
                    end else if (captured >= accepted.size()) begin
                        note_failure($sformatf("frame %h was never accepted", frame_byte));
                        captured++;
                    end else begin
                        compare_value("serial_out byte", 32'(frame_byte),
                                      32'(accepted[captured]));
                        captured++;
                    end
                end
            end
        join
        capture_frame(300, got, frame_byte);
        if (got) begin
            note_failure($sformatf("dropped byte went out anyway as %h", frame_byte));
        end
    endtask

    task automatic cycle_gap_test(input int gap, input logic [31:0] first_exp,
                                  input logic [31:0] delta_exp);
        logic [31:0] first;
        logic [31:0] second;
        bus_write(CYCLE_RST_ADDR, 32'h0);
        @(posedge clk);
        bus_addr <= CYCLE_ADDR;
        bus_re <= 1'b1;
        @(posedge clk);                        // First sampling edge
        bus_re <= 1'b0;
        @(negedge clk);
        first = bus_rdata;
        repeat (gap - 1) @(posedge clk);
        bus_re <= 1'b1;
        @(posedge clk);                        // Second sampling edge gap cycles later
        bus_re <= 1'b0;
        @(negedge clk);
        second = bus_rdata;
        compare_value("cycle_count first", first, first_exp);
        compare_value("cycle_count delta", second - first, delta_exp);
    endtask

    task automatic finish_test(input logic [8*24-1:0] name);
        tests++;
        if (test_errors == 0) begin
            $display("test %0s: ok", name);
        end else begin
            $display("test %0s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic run_stimulus();
        string line;
        logic [7:0] cmd;
        logic [31:0] arg1;
        logic [31:0] arg2;
        logic [31:0] arg3;
        logic [31:0] data;
        logic [8*24-1:0] name;
        int fd;
        int n;
        fd = $fopen("bench/uart_mmio_stim.txt", "r");
        if (fd == 0) begin
            note_failure("cannot open bench/uart_mmio_stim.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin   // Skip blanks and comments
                cmd = line.getc(0);
                arg1 = '0;
                arg2 = '0;
                arg3 = '0;
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", arg1, arg2, arg3);
                case (cmd)
                    "W": bus_write(arg1, arg2);
                    "R": begin
                        bus_read(arg1, data);
                        compare_value("bus_rdata", data, arg2);
                    end
                    "P": poll_status(arg1, arg2, arg3);
                    "S": send_frame(arg1[7:0]);
                    "T": expect_frame(arg1[7:0]);
                    "H": watch_line_high(arg1);
                    "F": fill_test();
                    "C": cycle_gap_test(arg1, arg2, arg3);
                    "E": begin
                        n = $sscanf(line.substr(1, line.len() - 1), "%s", name);
                        finish_test(name);
                    end
                    default: note_failure($sformatf("unknown stimulus command %c", cmd));
                endcase
            end
        end
        $fclose(fd);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        bus_addr = '0;
        bus_wdata = '0;
        bus_we = 1'b0;
        bus_re = 1'b0;
        serial_in = 1'b1;   // Idle line
        checks = 0;
        errors = 0;
        test_errors = 0;
        tests = 0;
        lfsr_state = 8'd79;
        fill_done = 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        run_stimulus();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- bench/uart_mmio_stim.txt
# One command per line, numbers in hex
# W addr data | R addr expected | P addr mask value | S byte in | T byte out
# H cycles high | F fill test | C gap first delta | E test name
R 80000000 00000001
H 14
E reset_state
W 80000008 000000a5
T a5
W 80000008 00000081
W 80000008 0000007e
T 81
T 7e
E transmit
S 5a
P 80000000 00000002 00000002
R 80000004 0000005a
R 80000000 00000001
S 3c
S 96
P 80000000 00000002 00000002
R 80000004 0000003c
R 80000004 00000096
R 80000000 00000001
E receive
F
E tx_backpressure
C 7 1 7
C 19 1 19
E cycle_counter

//--- uart_mmio.f
hw/mmio_pkg.sv
hw/uart_pkg.sv
hw/byte_fifo.sv
hw/baud_timer.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/mmio_regs.sv
hw/uart_mmio.sv
bench/uart_mmio_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module uart_mmio_tb -f uart_mmio.f -o uart_mmio_sim

out=$(./obj_dir/uart_mmio_sim)
echo "$out"

if echo "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1
